/* source/present_pkg.sv */
`default_nettype none

package present_pkg;

    // ##########################################################
    // Widths and counts.
    // ##########################################################

    localparam int BLOCK_WIDTH     = 64;
    localparam int KEY_WIDTH       = 80;
    localparam int NIBBLE_WIDTH    = 4;
    localparam int NUM_ROUNDS      = 31;
    localparam int NUM_ROUND_KEYS  = 32;
    localparam int ROUND_CNT_WIDTH = 5;

    // ##########################################################
    // Substitution tables, indexed by the input nibble.
    // ##########################################################

    localparam logic [NIBBLE_WIDTH-1:0] SBOX_ENC [0:15] = '{
        4'hC, 4'h5, 4'h6, 4'hB, 4'h9, 4'h0, 4'hA, 4'hD,
        4'h3, 4'hE, 4'hF, 4'h8, 4'h4, 4'h7, 4'h1, 4'h2
    };

    localparam logic [NIBBLE_WIDTH-1:0] SBOX_DEC [0:15] = '{
        4'h5, 4'hE, 4'hF, 4'h8, 4'hC, 4'h1, 4'h2, 4'hD,
        4'hB, 4'h4, 4'h6, 4'h3, 4'h0, 4'h7, 4'h9, 4'hA
    };

    // ##########################################################
    // Types.
    // ##########################################################

    typedef logic [BLOCK_WIDTH-1:0] block_t;
    typedef logic [KEY_WIDTH-1:0] key_t;

    // Entry i holds round key i.
    typedef logic [NUM_ROUND_KEYS-1:0][BLOCK_WIDTH-1:0] round_keys_t;

    typedef enum logic {
        MODE_ENC,
        MODE_DEC
    } cipher_mode_t;

    typedef enum logic [1:0] {
        KEY_LOAD,
        KEY_EXPAND,
        KEY_DONE
    } key_state_t;

    // Bit i goes to 16*i mod 63, the top bit stays.
    function automatic block_t p_layer(input block_t din);
        block_t dout;
        dout[BLOCK_WIDTH-1] = din[BLOCK_WIDTH-1];
        for (int i = 0; i < BLOCK_WIDTH - 1; i++) begin
            dout[(i * 16) % (BLOCK_WIDTH - 1)] = din[i];
        end
        return dout;
    endfunction

    function automatic block_t p_layer_inv(input block_t din);
        block_t dout;
        dout[BLOCK_WIDTH-1] = din[BLOCK_WIDTH-1];
        for (int i = 0; i < BLOCK_WIDTH - 1; i++) begin
            dout[i] = din[(i * 16) % (BLOCK_WIDTH - 1)];
        end
        return dout;
    endfunction

endpackage : present_pkg

`default_nettype wire

/* source/present_enc_round.sv */
`timescale 1ns/1ps
`default_nettype none

module present_enc_round (
    input  wire present_pkg::block_t block_i,
    input  wire present_pkg::block_t round_key_i,
    output present_pkg::block_t      block_o
);

    localparam int NUM_NIBBLES = present_pkg::BLOCK_WIDTH / present_pkg::NIBBLE_WIDTH;

    present_pkg::block_t sbox_out;
    present_pkg::block_t perm_out;

    // S-layer on all nibbles.
    for (genvar n = 0; n < NUM_NIBBLES; n++) begin : g_sbox
        assign sbox_out[n*present_pkg::NIBBLE_WIDTH +: present_pkg::NIBBLE_WIDTH] =
            present_pkg::SBOX_ENC[
                block_i[n*present_pkg::NIBBLE_WIDTH +: present_pkg::NIBBLE_WIDTH]];
    end

    assign perm_out = present_pkg::p_layer(sbox_out);

    // Key addition.
    assign block_o = perm_out ^ round_key_i;

endmodule : present_enc_round

`default_nettype wire

/* source/present_dec_round.sv */
`timescale 1ns/1ps
`default_nettype none

module present_dec_round (
    input  wire present_pkg::block_t block_i,
    input  wire present_pkg::block_t round_key_i,
    output present_pkg::block_t      block_o
);

    localparam int NUM_NIBBLES = present_pkg::BLOCK_WIDTH / present_pkg::NIBBLE_WIDTH;

    present_pkg::block_t perm_out;
    present_pkg::block_t sbox_out;

    // Undo the bit permutation first.
    assign perm_out = present_pkg::p_layer_inv(block_i);

    for (genvar n = 0; n < NUM_NIBBLES; n++) begin : g_sbox
        assign sbox_out[n*present_pkg::NIBBLE_WIDTH +: present_pkg::NIBBLE_WIDTH] =
            present_pkg::SBOX_DEC[
                perm_out[n*present_pkg::NIBBLE_WIDTH +: present_pkg::NIBBLE_WIDTH]];
    end

    // Key addition.
    assign block_o = sbox_out ^ round_key_i;

endmodule : present_dec_round

`default_nettype wire

/* source/present_enc_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module present_enc_datapath (
    input  wire present_pkg::round_keys_t round_keys_i,
    input  wire present_pkg::block_t      block_i,
    output present_pkg::block_t           block_o
);

    // stage[r] is the input of round r.
    present_pkg::block_t stage [0:present_pkg::NUM_ROUNDS];

    // Whitening with the first round key.
    assign stage[0] = block_i ^ round_keys_i[0];

    for (genvar r = 0; r < present_pkg::NUM_ROUNDS; r++) begin : g_round
        present_enc_round round_inst (
            .block_i     (stage[r]),
            .round_key_i (round_keys_i[r+1]),
            .block_o     (stage[r+1])
        );
    end

    assign block_o = stage[present_pkg::NUM_ROUNDS];

endmodule : present_enc_datapath

`default_nettype wire

/* source/present_dec_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module present_dec_datapath (
    input  wire present_pkg::round_keys_t round_keys_i,
    input  wire present_pkg::block_t      block_i,
    output present_pkg::block_t           block_o
);

    present_pkg::block_t stage [0:present_pkg::NUM_ROUNDS];

    // Strip the last round key first.
    assign stage[0] = block_i ^ round_keys_i[present_pkg::NUM_ROUND_KEYS-1];

    // Keys are consumed in reverse order, ending with key 0.
    for (genvar r = 0; r < present_pkg::NUM_ROUNDS; r++) begin : g_round
        present_dec_round round_inst (
            .block_i     (stage[r]),
            .round_key_i (round_keys_i[present_pkg::NUM_ROUNDS-1-r]),
            .block_o     (stage[r+1])
        );
    end

    assign block_o = stage[present_pkg::NUM_ROUNDS];

endmodule : present_dec_datapath

`default_nettype wire

/* source/present_key_schedule.sv */
`timescale 1ns/1ps
`default_nettype none

module present_key_schedule (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire present_pkg::key_t         key_i,
    output logic                           key_ready_o,
    output present_pkg::round_keys_t       round_keys_o
);

    present_pkg::key_state_t                   state;
    logic [present_pkg::ROUND_CNT_WIDTH-1:0]   round_cnt;
    logic [present_pkg::ROUND_CNT_WIDTH-1:0]   round_cnt_inc;
    logic                                      last_round;

    present_pkg::key_t                         key_reg;
    present_pkg::key_t                         key_rot;
    present_pkg::key_t                         key_sub;
    present_pkg::key_t                         key_next;
    present_pkg::round_keys_t                  round_keys;

    // ##########################################################
    // Key register update, one round key per cycle.
    // ##########################################################

    assign round_cnt_inc = round_cnt + present_pkg::ROUND_CNT_WIDTH'(1);
    assign last_round    = (round_cnt ==
        present_pkg::ROUND_CNT_WIDTH'(present_pkg::NUM_ROUND_KEYS - 1));

    // Rotate left by 61.
    assign key_rot = {key_reg[18:0], key_reg[present_pkg::KEY_WIDTH-1:19]};

    assign key_sub = {
        present_pkg::SBOX_ENC[key_rot[present_pkg::KEY_WIDTH-1 -: present_pkg::NIBBLE_WIDTH]],
        key_rot[present_pkg::KEY_WIDTH-present_pkg::NIBBLE_WIDTH-1:0]
    };

    // Round counter goes into bits 19..15.
    assign key_next = {
        key_sub[present_pkg::KEY_WIDTH-1:20],
        key_sub[19:15] ^ round_cnt_inc,
        key_sub[14:0]
    };

    // ##########################################################
    // Control FSM.
    // ##########################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= present_pkg::KEY_LOAD;
            round_cnt <= '0;
        end else begin
            case (state)
                present_pkg::KEY_LOAD: begin
                    round_cnt <= '0;
                    state     <= present_pkg::KEY_EXPAND;
                end
                present_pkg::KEY_EXPAND: begin
                    if (last_round) begin
                        state <= present_pkg::KEY_DONE;
                    end else begin
                        round_cnt <= round_cnt_inc;
                    end
                end
                default: begin
                    state <= present_pkg::KEY_DONE;
                end
            endcase
        end
    end

    // Key register and round key store.
    always_ff @(posedge clk) begin
        if (state == present_pkg::KEY_LOAD) begin
            key_reg <= key_i;
        end else if (state == present_pkg::KEY_EXPAND) begin
            round_keys[round_cnt] <=
                key_reg[present_pkg::KEY_WIDTH-1 -: present_pkg::BLOCK_WIDTH];
            if (!last_round) begin
                key_reg <= key_next;
            end
        end
    end

    assign round_keys_o = round_keys;
    assign key_ready_o  = (state == present_pkg::KEY_DONE);

endmodule : present_key_schedule

`default_nettype wire

/* source/present_cipher.sv */
`timescale 1ns/1ps
`default_nettype none

module present_cipher (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire present_pkg::cipher_mode_t mode_i,
    input  wire present_pkg::key_t         key_i,
    input  wire present_pkg::block_t       block_i,
    output logic                           key_ready_o,
    output present_pkg::block_t            block_o
);

    present_pkg::round_keys_t round_keys;
    present_pkg::block_t      enc_block;
    present_pkg::block_t      dec_block;

    // ##########################################################
    // Key expansion.
    // ##########################################################

    present_key_schedule key_schedule_inst (
        .clk          (clk),
        .rst          (rst),
        .key_i        (key_i),
        .key_ready_o  (key_ready_o),
        .round_keys_o (round_keys)
    );

    // ##########################################################
    // Both directions run in parallel.
    // ##########################################################

    present_enc_datapath enc_datapath_inst (
        .round_keys_i (round_keys),
        .block_i      (block_i),
        .block_o      (enc_block)
    );

    present_dec_datapath dec_datapath_inst (
        .round_keys_i (round_keys),
        .block_i      (block_i),
        .block_o      (dec_block)
    );

    // Output is only valid once key_ready_o is high.
    assign block_o = (mode_i == present_pkg::MODE_DEC) ? dec_block : enc_block;

endmodule : present_cipher

`default_nettype wire

/* bench/present_cipher_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module present_cipher_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int NUM_ENTRIES  = 4;
    localparam int RESET_CYCLES = 2;
    localparam int READY_LIMIT  = 40;
    localparam int NUM_RANDOM   = 8;
    localparam int NUM_TOGGLES  = 4;
    localparam int ENTRY_CYCLES = RESET_CYCLES + READY_LIMIT + 24;
    localparam int WATCHDOG_NS  = NUM_ENTRIES * ENTRY_CYCLES * CLK_PERIOD * 2;

    // Forward S-box of PRESENT. The inverse is built from it.
    localparam logic [3:0] SBOX_FWD [16] = '{
        4'hC, 4'h5, 4'h6, 4'hB, 4'h9, 4'h0, 4'hA, 4'hD,
        4'h3, 4'hE, 4'hF, 4'h8, 4'h4, 4'h7, 4'h1, 4'h2
    };

    // One published test vector.
    typedef struct packed {
        present_pkg::key_t   key;
        present_pkg::block_t plain;
        present_pkg::block_t cipher;
    } vector_t;

    logic                      clk;
    logic                      rst;
    present_pkg::cipher_mode_t mode;
    present_pkg::key_t         key;
    present_pkg::block_t       block_in;
    logic                      key_ready;
    present_pkg::block_t       block_out;

    vector_t vectors [NUM_ENTRIES];

    present_cipher present_cipher_inst (
        .clk         (clk),
        .rst         (rst),
        .mode_i      (mode),
        .key_i       (key),
        .block_i     (block_in),
        .key_ready_o (key_ready),
        .block_o     (block_out)
    );

    // ##########################################################
    // Clock and watchdog.
    // ##########################################################

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Simulation timed out after %0d ns without finishing the tests", WATCHDOG_NS);
        $display("Checks failed");
        $fatal(1);
    end

    // ##########################################################
    // Helper tasks.
    // ##########################################################

    task automatic check_value(
        input logic [63:0] actual,
        input logic [63:0] expected,
        input string       what
    );
        if (actual !== expected) begin
            $display("error at %0d ns: %s, got %h, expected %h",
                $time, what, actual, expected);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    // Reference model of PRESENT-80 decryption.
    function automatic logic [63:0] model_decrypt(
        input logic [79:0] key_in,
        input logic [63:0] din
    );
        logic [79:0] k;
        logic [63:0] rk [32];
        logic [3:0]  sbox_inv [16];
        logic [63:0] s;
        logic [63:0] t;
        for (int j = 0; j < 16; j++) begin
            sbox_inv[SBOX_FWD[j]] = 4'(j);
        end
        k = key_in;
        for (int r = 0; r < 32; r++) begin
            rk[r] = k[79:16];
            k = {k[18:0], k[79:19]};
            k[79:76] = SBOX_FWD[k[79:76]];
            k[19:15] = k[19:15] ^ 5'(r + 1);
        end
        s = din ^ rk[31];
        for (int r = 30; r >= 0; r--) begin
            // Bit i of the round input sits at 16*(i mod 4) + i/4 after the P-layer.
            for (int i = 0; i < 64; i++) begin
                t[i] = s[16 * (i % 4) + i / 4];
            end
            for (int n = 0; n < 16; n++) begin
                s[n*4 +: 4] = sbox_inv[t[n*4 +: 4]];
            end
            s = s ^ rk[r];
        end
        return s;
    endfunction

    // Holds reset for two cycles with the new key on the bus.
    task automatic reset_dut(input present_pkg::key_t new_key);
        @(negedge clk);
        rst      = 1'b1;
        key      = new_key;
        mode     = present_pkg::MODE_ENC;
        block_in = '0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_value(64'(key_ready), 64'd0, "key_ready_o high during reset");
        end
        rst = 1'b0;
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (key_ready !== 1'b1 && cycles < READY_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (key_ready !== 1'b1) begin
            $display("Key expansion did not finish within %0d cycles after reset",
                READY_LIMIT);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    // Called on a falling edge; returns the output one falling edge later.
    task automatic apply_block(
        input  present_pkg::cipher_mode_t new_mode,
        input  present_pkg::block_t       din,
        output present_pkg::block_t       dout
    );
        mode     = new_mode;
        block_in = din;
        @(negedge clk);
        check_value(64'(key_ready), 64'd1, "key_ready_o dropped after key expansion");
        dout = block_out;
    endtask

    // ##########################################################
    // Test sequence.
    // ##########################################################

    initial begin
        present_pkg::block_t       result;
        present_pkg::block_t       rnd_block;
        present_pkg::block_t       enc_block;
        present_pkg::block_t       dec_block;
        present_pkg::block_t       dec_expected;
        present_pkg::cipher_mode_t toggle_mode;

        rst      = 1'b1;
        mode     = present_pkg::MODE_ENC;
        key      = '0;
        block_in = '0;
        void'($urandom(32'hce89));

        // Key, plaintext, ciphertext.
        vectors[0] = {80'h0000_0000_0000_0000_0000, 64'h0000_0000_0000_0000,
                      64'h5579_C138_7B22_8445};
        vectors[1] = {80'hFFFF_FFFF_FFFF_FFFF_FFFF, 64'h0000_0000_0000_0000,
                      64'hE72C_46C0_F594_5049};
        vectors[2] = {80'h0000_0000_0000_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF,
                      64'hA112_FFC7_2F68_417B};
        vectors[3] = {80'hFFFF_FFFF_FFFF_FFFF_FFFF, 64'hFFFF_FFFF_FFFF_FFFF,
                      64'h3333_DCD3_2132_10D2};

        for (int e = 0; e < NUM_ENTRIES; e++) begin
            reset_dut(vectors[e].key);
            wait_ready();

            apply_block(present_pkg::MODE_ENC, vectors[e].plain, result);
            check_value(result, vectors[e].cipher, "encryption of table plaintext");
            apply_block(present_pkg::MODE_DEC, vectors[e].cipher, result);
            check_value(result, vectors[e].plain, "decryption of table ciphertext");

            for (int n = 0; n < NUM_RANDOM; n++) begin
                rnd_block = {$urandom, $urandom};
                apply_block(present_pkg::MODE_ENC, rnd_block, enc_block);
                apply_block(present_pkg::MODE_DEC, enc_block, result);
                check_value(result, rnd_block, "round trip of random block");
            end

            // Decryption of the plaintext, confirmed by encrypting it back.
            apply_block(present_pkg::MODE_DEC, vectors[e].plain, dec_block);
            apply_block(present_pkg::MODE_ENC, dec_block, result);
            check_value(result, vectors[e].plain, "encryption of decrypted plaintext");

            dec_expected = model_decrypt(vectors[e].key, vectors[e].plain);

            // Block stays put while only the mode changes
            for (int t = 0; t < NUM_TOGGLES; t++) begin
                toggle_mode = (t % 2 == 0) ? present_pkg::MODE_ENC : present_pkg::MODE_DEC;
                apply_block(toggle_mode, vectors[e].plain, result);
                if (toggle_mode == present_pkg::MODE_ENC) begin
                    check_value(result, vectors[e].cipher, "mode switch to encryption");
                end else begin
                    check_value(result, dec_expected, "mode switch to decryption");
                end
            end
        end

        $display("All checks passed");
        $finish;
    end

endmodule : present_cipher_tb

`default_nettype wire

/* present_cipher.f */
source/present_pkg.sv
source/present_enc_round.sv
source/present_dec_round.sv
source/present_enc_datapath.sv
source/present_dec_datapath.sv
source/present_key_schedule.sv
source/present_cipher.sv
bench/present_cipher_tb.sv

/* Makefile */
# Verilator build and run of the PRESENT-80 testbench.

TOP     := present_cipher_tb
OBJ_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 \
		--top-module $(TOP) \
		--Mdir $(OBJ_DIR) \
		-f present_cipher.f
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
